// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // system clock, 8 ns period
    localparam int CLK_FREQ_HZ  = 125_000_000;
    // picked so one serial bit is exactly 16 clocks
    localparam int BAUD_RATE    = 7_812_500;
    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;  // mid-bit sample point
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);  // bit-period counter width

    // framing is 8N1
    localparam int DATA_BITS    = 8;
    localparam int BIT_CNT_W    = $clog2(DATA_BITS);  // index into data bits

    typedef logic [DATA_BITS-1:0] byte_t;

    // receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,   // waiting for falling edge
        RX_START,  // checking start bit at its middle
        RX_DATA,   // sampling data bits, lsb first
        RX_STOP    // checking stop bit
    } rx_state_e;

    // transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,  // line held low for one bit
        TX_DATA,
        TX_STOP    // line held high for one bit
    } tx_state_e;

endpackage

`default_nettype wire

// ==== byte_path_if.sv ====
`default_nettype none

// byte hand-off from receiver through buffer to transmitter
interface byte_path_if
    import uart_pkg::*;
();

    byte_t rx_data;   // valid only in the rx_ready cycle
    logic  rx_ready;  // one-cycle pulse per good frame
    byte_t tx_data;   // held byte, stable while tx_start is high
    logic  tx_start;  // one-cycle launch strobe
    logic  tx_busy;   // high from cycle after tx_start to end of stop bit

    modport rx_mp (
        output rx_data,
        output rx_ready
    );

    modport buf_mp (
        input  rx_data,
        input  rx_ready,
        input  tx_busy,
        output tx_data,
        output tx_start
    );

    modport tx_mp (
        input  tx_data,
        input  tx_start,
        output tx_busy
    );

endinterface

`default_nettype wire

// ==== baud_timer.sv ====
`default_nettype none

module baud_timer import uart_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic run_i,  // engine active, counter free-runs
    output logic mid_o,  // middle of current bit
    output logic end_o   // last clock of current bit
);

    logic [BAUD_CNT_W-1:0] cnt_q;
    logic                  last_cnt;

    assign last_cnt = (cnt_q == BAUD_CNT_W'(CLKS_PER_BIT - 1));

    // counter parks at zero while idle so each frame starts aligned
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;
        end else if (last_cnt) begin
            cnt_q <= '0;  // wrap into next bit
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // strobes only while running
    assign mid_o = run_i && (cnt_q == BAUD_CNT_W'(HALF_BIT));
    assign end_o = run_i && last_cnt;

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       rxd_i,        // raw serial line, not clk_i related
    output logic       frame_err_o,  // pulse when stop bit reads low
    byte_path_if.rx_mp bp
);

    // input synchronizer and edge detect
    logic rxd_meta;  // first stage, may go metastable
    logic rxd_sync;  // second stage
    logic rxd_prev;  // one clock older copy
    logic rxd_fall;

    rx_state_e            state_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;
    byte_t                shift_q;    // assembled byte, lsb arrives first
    logic                 ready_q;

    logic run;
    logic mid_pulse;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxd_meta <= 1'b1;  // idle line is high
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign rxd_fall = rxd_prev && !rxd_sync;

    assign run = (state_q != RX_IDLE);

    baud_timer u_baud (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .run_i (run),
        .mid_o (mid_pulse),
        .end_o ()           // rx only samples at mid-bit
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= RX_IDLE;
            bit_cnt_q   <= '0;
            ready_q     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            ready_q     <= 1'b0;  // both outputs are single-cycle pulses
            frame_err_o <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (rxd_fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_pulse) begin
                        if (rxd_sync) begin
                            state_q <= RX_IDLE;  // too short, treat as glitch
                        end else begin
                            state_q   <= RX_DATA;
                            bit_cnt_q <= '0;
                        end
                    end
                end
                RX_DATA: begin
                    if (mid_pulse) begin
                        if (bit_cnt_q == BIT_CNT_W'(DATA_BITS - 1)) begin
                            state_q <= RX_STOP;
                        end
                        bit_cnt_q <= bit_cnt_q + 1'b1;  // wraps after last bit
                    end
                end
                RX_STOP: begin
                    if (mid_pulse) begin
                        ready_q     <= rxd_sync;   // good stop bit
                        frame_err_o <= !rxd_sync;  // low stop bit, byte dropped
                        state_q     <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // data shift, lsb first so new bits enter at the top
    always_ff @(posedge clk_i) begin
        if ((state_q == RX_DATA) && mid_pulse) begin
            shift_q <= {rxd_sync, shift_q[DATA_BITS-1:1]};
        end
    end

    // shift_q is untouched between last data bit and ready pulse
    assign bp.rx_data  = shift_q;
    assign bp.rx_ready = ready_q;

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    output logic       txd_o,  // registered line output
    byte_path_if.tx_mp bp
);

    tx_state_e            state_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;
    byte_t                shift_q;  // bit 0 is next to go out
    logic                 run;
    logic                 end_pulse;

    assign run        = (state_q != TX_IDLE);
    assign bp.tx_busy = run;  // rises the cycle after tx_start

    baud_timer u_baud (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .run_i (run),
        .mid_o (),           // tx steps on bit boundaries only
        .end_o (end_pulse)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= TX_IDLE;
            bit_cnt_q <= '0;
            txd_o     <= 1'b1;  // line idles high
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (bp.tx_start) begin
                        state_q <= TX_START;
                        txd_o   <= 1'b0;  // start bit
                    end
                end
                TX_START: begin
                    if (end_pulse) begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= '0;
                        txd_o     <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (end_pulse) begin
                        if (bit_cnt_q == BIT_CNT_W'(DATA_BITS - 1)) begin
                            state_q <= TX_STOP;
                            txd_o   <= 1'b1;  // stop bit
                        end else begin
                            txd_o <= shift_q[0];
                        end
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (end_pulse) begin
                        state_q <= TX_IDLE;  // busy drops here
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // load on launch, then shift one place per bit already on the line
    always_ff @(posedge clk_i) begin
        if ((state_q == TX_IDLE) && bp.tx_start) begin
            shift_q <= bp.tx_data;
        end else if (end_pulse && ((state_q == TX_START) || (state_q == TX_DATA))) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== echo_buffer.sv ====
`default_nettype none

module echo_buffer import uart_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    byte_path_if.buf_mp bp
);

    byte_t data_q;   // last received byte
    logic  avail_q;  // byte held and not yet sent
    logic  start_q;
    logic  launch;

    // transmitter free and something to send
    assign launch = avail_q && !bp.tx_busy;

    // newer byte simply replaces an unsent one
    always_ff @(posedge clk_i) begin
        if (bp.rx_ready) begin
            data_q <= bp.rx_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            avail_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= launch;  // one cycle, flag is gone next cycle
            // byte arriving with a launch is the one that goes out
            avail_q <= (avail_q || bp.rx_ready) && !launch;
        end
    end

    assign bp.tx_data  = data_q;
    assign bp.tx_start = start_q;

endmodule

`default_nettype wire

// ==== uart_echo_top.sv ====
`default_nettype none

module uart_echo_top (
    input  logic clk_i,
    input  logic rst_i,
    input  logic rxd_i,       // serial in
    output logic txd_o,       // serial echo out
    output logic frame_err_o  // pulse per frame with a low stop bit
);

    // rx -> buffer -> tx
    byte_path_if bp ();

    // receiver, fills the byte path
    uart_rx u_rx (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rxd_i       (rxd_i),
        .frame_err_o (frame_err_o),
        .bp          (bp.rx_mp)
    );

    // one-byte holding stage
    echo_buffer u_buf (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bp    (bp.buf_mp)
    );

    // transmitter drives the pin directly
    uart_tx u_tx (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .txd_o (txd_o),
        .bp    (bp.tx_mp)
    );

endmodule

`default_nettype wire

// ==== uart_echo_asserts.sv ====
`default_nettype none

module uart_echo_asserts (
    input logic clk_i,
    input logic rst_i,
    input logic tx_start_i,  // launch strobe from the buffer
    input logic tx_busy_i    // transmitter activity
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // read back by the testbench at the end

    // launch only into an idle transmitter
    start_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_start_i |-> !tx_busy_i)
        else begin
            fail_count++;
            $error("tx_start raised while tx_busy is high");
        end

    // strobe, never a level
    start_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_start_i |=> !tx_start_i)
        else begin
            fail_count++;
            $error("tx_start held for more than one cycle");
        end

    // transmitter picks up the launch right away
    busy_follows_start: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_start_i |=> tx_busy_i)
        else begin
            fail_count++;
            $error("tx_busy did not rise in the cycle after tx_start");
        end

endmodule

bind echo_buffer uart_echo_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tx_start_i (bp.tx_start),
    .tx_busy_i  (bp.tx_busy)
);

`default_nettype wire

// ==== tb_uart_echo.sv ====
`default_nettype none

module tb_uart_echo import uart_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_BITS     = DATA_BITS + 2;  // start + data + stop
    localparam int TABLE_SIZE     = 9;
    localparam int TIMEOUT_CYCLES = TABLE_SIZE * 3 * FRAME_BITS * CLKS_PER_BIT + 200;
    localparam int GLITCH_CLKS    = HALF_BIT / 2;   // well short of the start-bit recheck

    typedef struct packed {
        byte_t data;
        logic  stop_bit;
        logic  glitch;    // short low pulse instead of a frame
        logic  echo;      // byte expected back on txd_o
    } stim_t;

    logic clk_i;
    logic rst_i;
    logic rxd_i;
    logic txd_o;
    logic frame_err_o;

    stim_t table_q [TABLE_SIZE];
    byte_t echo_q [$];          // bytes decoded from txd_o, oldest first
    int    tx_frames      = 0;  // start bits seen on txd_o
    int    ferr_count     = 0;  // cycles with frame_err_o high
    int    errors         = 0;
    int    checks         = 0;
    int    tests_run      = 0;
    int    tests_failed   = 0;
    int    test_err_start = 0;
    int    seed;

    uart_echo_top DUT (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rxd_i       (rxd_i),
        .txd_o       (txd_o),
        .frame_err_o (frame_err_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;  // 8 ns period

    // frame_err_o is a one-cycle pulse, so high cycles = pulses
    always @(negedge clk_i) begin
        if (!rst_i && frame_err_o) begin
            ferr_count++;
        end
    end

    function automatic stim_t make_entry(input byte_t data, input logic stop_bit,
                                         input logic glitch);
        stim_t e;
        e.data     = data;
        e.stop_bit = stop_bit;
        e.glitch   = glitch;
        e.echo     = stop_bit && !glitch;  // only clean frames come back
        return e;
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("CHECK FAILED at %0d ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_condition(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR at %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED, %0d errors", tests_run, name,
                     errors - test_err_start);
        end
    endtask

    // one serial bit, entered and left 1 ns after a rising edge
    task automatic drive_bit(input logic value);
        rxd_i = value;
        repeat (CLKS_PER_BIT) @(posedge clk_i);
        #1;
    endtask

    task automatic send_frame(input byte_t data, input logic stop_bit);
        int i;
        drive_bit(1'b0);  // start
        for (i = 0; i < DATA_BITS; i++) begin
            drive_bit(data[i]);  // lsb first
        end
        drive_bit(stop_bit);
        rxd_i = 1'b1;  // back to idle, also after a low stop bit
    endtask

    task automatic send_glitch();
        rxd_i = 1'b0;
        repeat (GLITCH_CLKS) @(posedge clk_i);
        #1;
        rxd_i = 1'b1;
    endtask

    task automatic hold_idle(input int clks);
        rxd_i = 1'b1;
        repeat (clks) @(posedge clk_i);
        #1;
    endtask

    // block until count bytes are queued or limit cycles pass
    task automatic wait_for_echoes(input int count, input int limit, output bit ok);
        int n;
        n = 0;
        while ((echo_q.size() < count) && (n < limit)) begin
            @(posedge clk_i);
            n++;
        end
        #1;
        ok = (echo_q.size() >= count);
    endtask

    // serial decoder, samples txd_o at mid-bit on falling clock edges
    initial begin : decoder
        byte_t value;
        int    i;
        forever begin
            @(negedge clk_i);
            if (!rst_i && (txd_o == 1'b0)) begin
                tx_frames++;
                repeat (HALF_BIT) @(negedge clk_i);  // middle of start bit
                compare_value("txd_o start bit", 0, int'(txd_o));
                for (i = 0; i < DATA_BITS; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk_i);
                    value[i] = txd_o;
                end
                repeat (CLKS_PER_BIT) @(negedge clk_i);
                compare_value("txd_o stop bit", 1, int'(txd_o));
                echo_q.push_back(value);
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        bit ok;
        int ferr_before;
        int frames_before;
        int good_count;
        int rnd;
        int n;
        int t;

        rst_i = 1'b1;
        rxd_i = 1'b1;
        seed  = 28595;
        good_count = 0;

        // corner bytes, then random ones mixed with a bad stop bit and a glitch
        table_q[0] = make_entry(8'h00, 1'b1, 1'b0);
        table_q[1] = make_entry(8'hFF, 1'b1, 1'b0);
        table_q[2] = make_entry(8'h55, 1'b1, 1'b0);
        table_q[3] = make_entry(8'hA5, 1'b1, 1'b0);
        rnd = $random(seed);
        table_q[4] = make_entry(rnd[7:0], 1'b1, 1'b0);
        rnd = $random(seed);
        table_q[5] = make_entry(rnd[7:0], 1'b0, 1'b0);  // low stop bit
        rnd = $random(seed);
        table_q[6] = make_entry(rnd[7:0], 1'b1, 1'b0);
        table_q[7] = make_entry(8'h00, 1'b1, 1'b1);     // glitch only
        rnd = $random(seed);
        table_q[8] = make_entry(rnd[7:0], 1'b1, 1'b0);

        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // quiet line after reset
        begin_test();
        for (n = 0; n < 2 * CLKS_PER_BIT; n++) begin
            @(negedge clk_i);
            compare_value("txd_o", 1, int'(txd_o));
            compare_value("frame_err_o", 0, int'(frame_err_o));
        end
        @(posedge clk_i);
        #1;
        end_test("idle after reset");

        // one entry at a time with idle time in between
        for (t = 0; t < TABLE_SIZE; t++) begin
            begin_test();
            ferr_before   = ferr_count;
            frames_before = tx_frames;
            if (table_q[t].glitch) begin
                send_glitch();
                hold_idle((FRAME_BITS + 2) * CLKS_PER_BIT);
                compare_value("frame_err_o pulses", 0, ferr_count - ferr_before);
                compare_value("echo frames on txd_o", 0, tx_frames - frames_before);
            end else begin
                send_frame(table_q[t].data, table_q[t].stop_bit);
                if (table_q[t].echo) begin
                    good_count++;
                    wait_for_echoes(1, 2 * FRAME_BITS * CLKS_PER_BIT, ok);
                    check_condition(ok, $sformatf("no echo of byte %02h on txd_o",
                                                  table_q[t].data));
                    if (ok) begin
                        compare_value("echoed byte", int'(table_q[t].data),
                                      int'(echo_q.pop_front()));
                    end
                    hold_idle(2 * CLKS_PER_BIT);  // room for a repeated echo to start
                    compare_value("echo frames on txd_o", 1, tx_frames - frames_before);
                    compare_value("frame_err_o pulses", 0, ferr_count - ferr_before);
                end else begin
                    hold_idle(4 * CLKS_PER_BIT);  // an echo would have started by now
                    compare_value("frame_err_o pulses", 1, ferr_count - ferr_before);
                    compare_value("echo frames on txd_o", 0, tx_frames - frames_before);
                end
            end
            end_test($sformatf("entry %0d byte %02h", t, table_q[t].data));
        end

        // clean frames again with no idle time between them
        begin_test();
        ferr_before   = ferr_count;
        frames_before = tx_frames;
        for (t = 0; t < TABLE_SIZE; t++) begin
            if (table_q[t].echo) begin
                send_frame(table_q[t].data, 1'b1);
            end
        end
        wait_for_echoes(good_count, 2 * FRAME_BITS * CLKS_PER_BIT, ok);
        check_condition(ok, "back-to-back echoes did not all arrive");
        hold_idle(2 * CLKS_PER_BIT);  // room for a stray extra frame to start
        compare_value("echo frames on txd_o", good_count, tx_frames - frames_before);
        compare_value("frame_err_o pulses", 0, ferr_count - ferr_before);
        for (t = 0; t < TABLE_SIZE; t++) begin
            if (table_q[t].echo && (echo_q.size() > 0)) begin
                compare_value($sformatf("echoed byte %0d", t), int'(table_q[t].data),
                              int'(echo_q.pop_front()));
            end
        end
        compare_value("leftover echoes", 0, echo_q.size());
        end_test("back-to-back frames");

        // whole-run totals
        begin_test();
        compare_value("total echo frames", 2 * good_count, tx_frames);
        check_condition(DUT.u_buf.u_asserts.fail_count == 0,
                        "bound assertions on the byte path failed");
        end_test("totals");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
uart_pkg.sv
byte_path_if.sv
baud_timer.sv
uart_rx.sv
uart_tx.sv
echo_buffer.sv
uart_echo_top.sv
uart_echo_asserts.sv
tb_uart_echo.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_uart_echo
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUN_FLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
